//--- filelist.f
hdl/cache_geom_pkg.sv
hdl/cache_bus_pkg.sv
hdl/way_ram.sv
hdl/line_meta.sv
hdl/dcache_ctrl.sv
hdl/line_buffer.sv
hdl/dcache_top.sv
verif/mem_model.sv
verif/tb_dcache.sv

//--- hdl/cache_bus_pkg.sv
package cache_bus_pkg;

	// one CPU access as captured by the cache
	// addr is a byte address, word aligned
	typedef struct packed {
		logic                  wr;
		cache_geom_pkg::word_t addr;
		cache_geom_pkg::word_t wdata;
		cache_geom_pkg::strb_t wstrb;
	} cpu_req_t;

	// one burst beat, shared by refill and write-back channels
	typedef struct packed {
		cache_geom_pkg::word_t data;
		logic                  last;
	} mem_beat_t;

endpackage

//--- hdl/cache_geom_pkg.sv
package cache_geom_pkg;

	// associativity is fixed, the replacement tree below assumes four ways
	localparam int WAYS = 4;

	// words per line, also the number of beats in every memory burst
	localparam int WORDS_PER_LINE = 8;

	typedef logic [31:0] word_t;

	// one full line, word 0 in the low bits
	typedef logic [WORDS_PER_LINE*32-1:0] line_t;

	typedef logic [3:0] strb_t;

	// one-hot way select
	typedef logic [WAYS-1:0] way_vec_t;

	// tree bits of one set
	// bit 0 root, set when ways 0/1 were used last
	// bit 1 left pair, set when way 0 was used last
	// bit 2 right pair, set when way 2 was used last
	typedef logic [WAYS-2:0] plru_t;

	// word index inside a line
	typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;

endpackage

//--- hdl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl #(
	parameter int  SETS  = 32,
	localparam int SET_W = $clog2(SETS),
	localparam int OFF_W = $clog2(cache_geom_pkg::WORDS_PER_LINE) + 2,
	localparam int TAG_W = 32 - SET_W - OFF_W
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    req_valid,
	input  cache_bus_pkg::cpu_req_t cpu_in,
	output logic                    req_ready,
	output logic                    rsp_valid,
	input  logic                    rsp_ready,
	input  logic                    hit,
	input  logic                    victim_dirty,
	input  logic [TAG_W-1:0]        victim_tag,
	output cache_bus_pkg::cpu_req_t req,
	output logic                    lookup,
	output logic                    evict,
	output logic                    fill,
	output logic                    write_line,
	output logic                    load_victim,
	output logic                    shift_out,
	output logic                    shift_in,
	output logic                    rd_req_valid,
	input  logic                    rd_req_ready,
	output cache_geom_pkg::word_t   rd_req_addr,
	input  logic                    rd_rsp_valid,
	input  logic                    rd_rsp_last,
	output logic                    rd_rsp_ready,
	output logic                    wr_req_valid,
	input  logic                    wr_req_ready,
	output cache_geom_pkg::word_t   wr_req_addr,
	output logic                    wr_data_valid,
	input  logic                    wr_data_ready,
	output logic                    wr_beat_last
);

	typedef enum logic [10:0] {
		S_WAIT     = 11'b000_0000_0001,
		S_LOOKUP   = 11'b000_0000_0010,
		S_EVICT    = 11'b000_0000_0100,
		S_WR_REQ   = 11'b000_0000_1000,
		S_TXD      = 11'b000_0001_0000,
		S_RD_REQ   = 11'b000_0010_0000,
		S_RECV     = 11'b000_0100_0000,
		S_REFILL   = 11'b000_1000_0000,
		S_CACHE_WR = 11'b001_0000_0000,
		S_CACHE_RD = 11'b010_0000_0000,
		S_RESP     = 11'b100_0000_0000
	} state_t;

	state_t state;
	state_t next_state;

	cache_geom_pkg::word_sel_t beat_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_WAIT;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			S_WAIT:     if (req_valid) next_state = S_LOOKUP;
			S_LOOKUP: begin
				if (hit) begin
					next_state = req.wr ? S_CACHE_WR : S_CACHE_RD;
				end else begin
					next_state = S_EVICT;
				end
			end
			S_EVICT:    next_state = victim_dirty ? S_WR_REQ : S_RD_REQ;
			S_WR_REQ:   if (wr_req_ready) next_state = S_TXD;
			S_TXD:      if (wr_data_ready && wr_beat_last) next_state = S_RD_REQ;
			S_RD_REQ:   if (rd_req_ready) next_state = S_RECV;
			S_RECV:     if (rd_rsp_valid && rd_rsp_last) next_state = S_REFILL;
			S_REFILL:   next_state = req.wr ? S_CACHE_WR : S_CACHE_RD;
			S_CACHE_WR: next_state = S_WAIT;
			S_CACHE_RD: next_state = S_RESP;
			S_RESP:     if (rsp_ready) next_state = S_WAIT;
			default:    next_state = S_WAIT;
		endcase
	end

	// request held for the whole access
	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			req <= cpu_in;
		end
	end

	// write-back beat count, restarts when the burst is granted
	always_ff @(posedge clk) begin
		if (rst) begin
			beat_cnt <= '0;
		end else if (load_victim) begin
			beat_cnt <= '0;
		end else if (shift_out) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	assign req_ready  = (state == S_WAIT);
	assign rsp_valid  = (state == S_RESP);
	assign lookup     = (state == S_LOOKUP);
	assign evict      = (state == S_EVICT);
	assign fill       = (state == S_REFILL);
	assign write_line = (state == S_CACHE_WR);

	assign load_victim = (state == S_WR_REQ) && wr_req_ready;
	assign shift_out   = wr_data_valid && wr_data_ready;
	assign shift_in    = rd_rsp_valid && rd_rsp_ready;

	assign rd_req_valid  = (state == S_RD_REQ);
	assign rd_rsp_ready  = (state == S_RECV);
	assign wr_req_valid  = (state == S_WR_REQ);
	assign wr_data_valid = (state == S_TXD);
	assign wr_beat_last  = wr_data_valid && (beat_cnt == cache_geom_pkg::word_sel_t'('1));

	// line aligned, the victim keeps the set of the request
	assign rd_req_addr = {req.addr[31:OFF_W], {OFF_W{1'b0}}};
	assign wr_req_addr = {victim_tag, req.addr[OFF_W +: SET_W], {OFF_W{1'b0}}};

	a_ready_rsp_excl: assert property (@(posedge clk) disable iff (rst)
		!(req_ready && rsp_valid));

endmodule

//--- hdl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
	parameter int  SETS  = 32,
	localparam int SET_W = $clog2(SETS),
	localparam int OFF_W = $clog2(cache_geom_pkg::WORDS_PER_LINE) + 2,
	localparam int TAG_W = 32 - SET_W - OFF_W
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     req_valid,
	input  cache_bus_pkg::cpu_req_t  cpu_req,
	output logic                     req_ready,
	output logic                     rsp_valid,
	output cache_geom_pkg::word_t    rsp_data,
	input  logic                     rsp_ready,
	output logic                     rd_req_valid,
	output cache_geom_pkg::word_t    rd_req_addr,
	input  logic                     rd_req_ready,
	input  logic                     rd_rsp_valid,
	input  cache_bus_pkg::mem_beat_t rd_rsp_beat,
	output logic                     rd_rsp_ready,
	output logic                     wr_req_valid,
	output cache_geom_pkg::word_t    wr_req_addr,
	input  logic                     wr_req_ready,
	output logic                     wr_data_valid,
	output cache_bus_pkg::mem_beat_t wr_data_beat,
	input  logic                     wr_data_ready
);

	localparam int WAYS = cache_geom_pkg::WAYS;

	cache_bus_pkg::cpu_req_t               req;
	logic                                  lookup;
	logic                                  evict;
	logic                                  fill;
	logic                                  write_line;
	logic                                  load_victim;
	logic                                  shift_out;
	logic                                  shift_in;
	logic                                  hit;
	logic                                  victim_dirty;
	logic [TAG_W-1:0]                      victim_tag;
	logic                                  wr_beat_last;
	cache_geom_pkg::word_t                 wr_data;
	cache_geom_pkg::way_vec_t              way_sel;
	cache_geom_pkg::way_vec_t              way_wen;
	cache_geom_pkg::line_t                 wdata_line;
	cache_geom_pkg::line_t [WAYS-1:0]      way_lines;

	assign way_wen      = {WAYS{fill | write_line}} & way_sel;
	assign wr_data_beat = '{data: wr_data, last: wr_beat_last};

	dcache_ctrl #(.SETS(SETS)) i_ctrl (
		.clk           (clk),
		.rst           (rst),
		.req_valid     (req_valid),
		.cpu_in        (cpu_req),
		.req_ready     (req_ready),
		.rsp_valid     (rsp_valid),
		.rsp_ready     (rsp_ready),
		.hit           (hit),
		.victim_dirty  (victim_dirty),
		.victim_tag    (victim_tag),
		.req           (req),
		.lookup        (lookup),
		.evict         (evict),
		.fill          (fill),
		.write_line    (write_line),
		.load_victim   (load_victim),
		.shift_out     (shift_out),
		.shift_in      (shift_in),
		.rd_req_valid  (rd_req_valid),
		.rd_req_ready  (rd_req_ready),
		.rd_req_addr   (rd_req_addr),
		.rd_rsp_valid  (rd_rsp_valid),
		.rd_rsp_last   (rd_rsp_beat.last),
		.rd_rsp_ready  (rd_rsp_ready),
		.wr_req_valid  (wr_req_valid),
		.wr_req_ready  (wr_req_ready),
		.wr_req_addr   (wr_req_addr),
		.wr_data_valid (wr_data_valid),
		.wr_data_ready (wr_data_ready),
		.wr_beat_last  (wr_beat_last)
	);

	line_meta #(.SETS(SETS)) i_meta (
		.clk          (clk),
		.rst          (rst),
		.req          (req),
		.lookup       (lookup),
		.evict        (evict),
		.fill         (fill),
		.write_line   (write_line),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.way_sel      (way_sel)
	);

	line_buffer #(.SETS(SETS)) i_lbuf (
		.clk         (clk),
		.req         (req),
		.way_lines   (way_lines),
		.way_sel     (way_sel),
		.load_victim (load_victim),
		.shift_out   (shift_out),
		.shift_in    (shift_in),
		.write_line  (write_line),
		.refill_data (rd_rsp_beat.data),
		.wr_data     (wr_data),
		.rsp_data    (rsp_data),
		.wdata_line  (wdata_line)
	);

	// one line store per way, all indexed by the request set
	for (genvar i = 0; i < WAYS; i++) begin : g_way
		way_ram #(
			.SETS    (SETS),
			.entry_t (cache_geom_pkg::line_t)
		) i_data_way (
			.clk   (clk),
			.set   (req.addr[OFF_W +: SET_W]),
			.wen   (way_wen[i]),
			.wdata (wdata_line),
			.rdata (way_lines[i])
		);
	end

endmodule

//--- hdl/line_buffer.sv
`timescale 1ns/1ps

module line_buffer #(
	parameter int SETS = 32
) (
	input  logic                                              clk,
	input  cache_bus_pkg::cpu_req_t                           req,
	input  cache_geom_pkg::line_t [cache_geom_pkg::WAYS-1:0]  way_lines,
	input  cache_geom_pkg::way_vec_t                          way_sel,
	input  logic                                              load_victim,
	input  logic                                              shift_out,
	input  logic                                              shift_in,
	input  logic                                              write_line,
	input  cache_geom_pkg::word_t                             refill_data,
	output cache_geom_pkg::word_t                             wr_data,
	output cache_geom_pkg::word_t                             rsp_data,
	output cache_geom_pkg::line_t                             wdata_line
);

	localparam int LINE_W = $bits(cache_geom_pkg::line_t);

	cache_geom_pkg::line_t     sel_line;
	cache_geom_pkg::line_t     merged_line;
	cache_geom_pkg::line_t     line_q;
	cache_geom_pkg::word_t     merged_word;
	cache_geom_pkg::word_sel_t word_idx;

	// set index is taken as a plain address field
	if (SETS < 2 || (SETS & (SETS - 1)) != 0) begin : g_sets_check
		$error("SETS must be a power of two");
	end

	assign word_idx = req.addr[2 +: $bits(cache_geom_pkg::word_sel_t)];

	always_comb begin
		sel_line = '0;
		for (int i = 0; i < cache_geom_pkg::WAYS; i++) begin
			if (way_sel[i]) begin
				sel_line = sel_line | way_lines[i];
			end
		end
	end

	assign rsp_data = sel_line[word_idx*32 +: 32];

	// byte lanes without strobe keep the cached value
	always_comb begin
		for (int b = 0; b < 4; b++) begin
			merged_word[b*8 +: 8] = req.wstrb[b] ? req.wdata[b*8 +: 8] : rsp_data[b*8 +: 8];
		end
		merged_line = sel_line;
		merged_line[word_idx*32 +: 32] = merged_word;
	end

	// victim leaves low word first, refill beats enter at the top
	always_ff @(posedge clk) begin
		if (load_victim) begin
			line_q <= sel_line;
		end else if (shift_out) begin
			line_q <= {32'b0, line_q[LINE_W-1:32]};
		end else if (shift_in) begin
			line_q <= {refill_data, line_q[LINE_W-1:32]};
		end
	end

	assign wr_data    = line_q[31:0];
	assign wdata_line = write_line ? merged_line : line_q;

	a_shift_excl: assert property (@(posedge clk)
		!(shift_in && shift_out));

endmodule

//--- hdl/line_meta.sv
`timescale 1ns/1ps

module line_meta #(
	parameter int   SETS  = 32,
	localparam int  SET_W = $clog2(SETS),
	localparam int  OFF_W = $clog2(cache_geom_pkg::WORDS_PER_LINE) + 2,
	localparam int  TAG_W = 32 - SET_W - OFF_W
) (
	input  logic                      clk,
	input  logic                      rst,
	input  cache_bus_pkg::cpu_req_t   req,
	input  logic                      lookup,
	input  logic                      evict,
	input  logic                      fill,
	input  logic                      write_line,
	output logic                      hit,
	output logic                      victim_dirty,
	output logic [TAG_W-1:0]          victim_tag,
	output cache_geom_pkg::way_vec_t  way_sel
);

	localparam int WAYS = cache_geom_pkg::WAYS;

	logic [SET_W-1:0] set;
	logic [TAG_W-1:0] tag;
	logic [TAG_W-1:0] tags [WAYS];

	cache_geom_pkg::way_vec_t [SETS-1:0] valid;
	cache_geom_pkg::way_vec_t [SETS-1:0] dirty;
	cache_geom_pkg::plru_t    [SETS-1:0] plru;

	cache_geom_pkg::way_vec_t hit_vec;
	cache_geom_pkg::way_vec_t victim_vec;
	cache_geom_pkg::way_vec_t valid_set;
	cache_geom_pkg::plru_t    plru_set;

	// mark the touched way as most recent on every level it passes
	function automatic cache_geom_pkg::plru_t plru_touch(
		input cache_geom_pkg::plru_t    p,
		input cache_geom_pkg::way_vec_t w
	);
		cache_geom_pkg::plru_t n;
		n = p;
		if (w[0] || w[1]) begin
			n[0] = 1'b1;
			n[1] = w[0];
		end else begin
			n[0] = 1'b0;
			n[2] = w[2];
		end
		return n;
	endfunction

	assign set = req.addr[OFF_W +: SET_W];
	assign tag = req.addr[31 -: TAG_W];

	for (genvar i = 0; i < WAYS; i++) begin : g_tag
		way_ram #(
			.SETS    (SETS),
			.entry_t (logic [TAG_W-1:0])
		) i_tag_way (
			.clk   (clk),
			.set   (set),
			.wen   (fill & way_sel[i]),
			.wdata (tag),
			.rdata (tags[i])
		);
		assign hit_vec[i] = valid[set][i] && (tags[i] == tag);
	end

	assign hit       = |hit_vec;
	assign valid_set = valid[set];
	assign plru_set  = plru[set];

	// empty ways go first, lowest index wins
	// with a full set walk the tree away from the recent side
	always_comb begin
		victim_vec = '0;
		if (&valid_set) begin
			if (plru_set[0]) begin
				victim_vec = plru_set[2] ? 4'b1000 : 4'b0100;
			end else begin
				victim_vec = plru_set[1] ? 4'b0010 : 4'b0001;
			end
		end else begin
			for (int i = WAYS - 1; i >= 0; i--) begin
				if (!valid_set[i]) begin
					victim_vec = cache_geom_pkg::way_vec_t'(1) << i;
				end
			end
		end
	end

	assign victim_dirty = |(victim_vec & valid_set & dirty[set]);

	// tag of the registered way, used for the write-back address
	always_comb begin
		victim_tag = '0;
		for (int i = 0; i < WAYS; i++) begin
			if (way_sel[i]) begin
				victim_tag = victim_tag | tags[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid   <= '0;
			dirty   <= '0;
			plru    <= '0;
			way_sel <= '0;
		end else begin
			if (lookup && hit) begin
				way_sel <= hit_vec;
			end else if (evict) begin
				way_sel <= victim_vec;
			end
			if (fill) begin
				valid[set] <= valid[set] | way_sel;
				dirty[set] <= dirty[set] & ~way_sel;
			end
			if (write_line) begin
				dirty[set] <= dirty[set] | way_sel;
			end
			// every access is either a hit at lookup or a fill after a miss
			if (lookup && hit) begin
				plru[set] <= plru_touch(plru_set, hit_vec);
			end else if (fill) begin
				plru[set] <= plru_touch(plru_set, way_sel);
			end
		end
	end

	a_way_sel_onehot: assert property (@(posedge clk) disable iff (rst)
		(fill || write_line) |-> $onehot(way_sel));

endmodule

//--- hdl/way_ram.sv
`timescale 1ns/1ps

module way_ram #(
	parameter int  SETS    = 32,
	parameter type entry_t = logic
) (
	input  logic                    clk,
	input  logic [$clog2(SETS)-1:0] set,
	input  logic                    wen,
	input  entry_t                  wdata,
	output entry_t                  rdata
);

	entry_t mem [SETS];

	// write lands on the edge, read follows the set index directly
	always_ff @(posedge clk) begin
		if (wen) begin
			mem[set] <= wdata;
		end
	end

	assign rdata = mem[set];

endmodule

//--- run_sim.sh
#!/bin/sh
# build the data cache testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_dcache \
	-o sim_dcache > sim.log 2>&1 &&
	./obj_dir/sim_dcache >> sim.log 2>&1 ||
	echo "build or simulation stopped with an error" >> sim.log
cat sim.log
grep -qx "Regression passed" sim.log && exit 0 || exit 1

//--- verif/mem_model.sv
`timescale 1ns/1ps

module mem_model (
	input  logic                     clk,
	input  logic                     rd_req_valid,
	input  cache_geom_pkg::word_t    rd_req_addr,
	output logic                     rd_req_ready,
	output logic                     rd_rsp_valid,
	output cache_bus_pkg::mem_beat_t rd_rsp_beat,
	input  logic                     rd_rsp_ready,
	input  logic                     wr_req_valid,
	input  cache_geom_pkg::word_t    wr_req_addr,
	output logic                     wr_req_ready,
	input  logic                     wr_data_valid,
	input  cache_bus_pkg::mem_beat_t wr_data_beat,
	output logic                     wr_data_ready,
	output int                       rd_bursts,
	output int                       wr_bursts,
	output cache_geom_pkg::word_t    wr_last_addr,
	output cache_geom_pkg::line_t    wr_last_line,
	output int                       proto_errors
);

	// 16 KB of word storage, enough for every address the tests use
	localparam int DEPTH = 4096;
	localparam int BEATS = cache_geom_pkg::WORDS_PER_LINE;

	cache_geom_pkg::word_t shadow [DEPTH];
	logic [31:0]           rand_state;
	logic                  rd_busy;
	logic                  wr_busy;
	int                    rd_base;
	int                    wr_base;
	int                    rd_cnt;
	int                    wr_cnt;

	function automatic cache_geom_pkg::word_t scramble(input cache_geom_pkg::word_t a);
		return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
	endfunction

	// ready about five cycles in eight
	function automatic logic next_ready();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return rand_state[18:16] > 3'd2;
	endfunction

	initial begin
		rand_state   = 32'd49;
		rd_busy      = 1'b0;
		wr_busy      = 1'b0;
		rd_base      = 0;
		wr_base      = 0;
		rd_cnt       = 0;
		wr_cnt       = 0;
		rd_req_ready = 1'b0;
		rd_rsp_valid = 1'b0;
		rd_rsp_beat  = '0;
		wr_req_ready = 1'b0;
		wr_data_ready = 1'b0;
		rd_bursts    = 0;
		wr_bursts    = 0;
		wr_last_addr = '0;
		wr_last_line = '0;
		proto_errors = 0;
		for (int i = 0; i < DEPTH; i++) begin
			shadow[i] = scramble(cache_geom_pkg::word_t'(i) << 2);
		end
	end

	// outputs change on the falling edge, a handshake is counted when it will
	// complete at the next rising edge
	always @(negedge clk) begin
		rd_rsp_valid = rd_busy && next_ready();
		rd_rsp_beat.data = rd_busy ? shadow[rd_base + rd_cnt] : '0;
		rd_rsp_beat.last = rd_busy && (rd_cnt == BEATS - 1);
		if (rd_rsp_valid && rd_rsp_ready) begin
			rd_cnt++;
			if (rd_cnt == BEATS) begin
				rd_busy = 1'b0;
			end
		end
		rd_req_ready = !rd_busy && next_ready();
		if (rd_req_valid && rd_req_ready) begin
			if (rd_req_addr[31:14] != '0 || rd_req_addr[4:0] != '0) begin
				proto_errors++;
			end
			rd_busy = 1'b1;
			rd_base = int'(rd_req_addr[13:2]);
			rd_cnt  = 0;
			rd_bursts++;
		end

		wr_data_ready = wr_busy && next_ready();
		if (wr_data_valid && wr_data_ready) begin
			shadow[wr_base + wr_cnt] = wr_data_beat.data;
			wr_last_line[wr_cnt*32 +: 32] = wr_data_beat.data;
			// last belongs on the final beat only
			if (wr_data_beat.last != (wr_cnt == BEATS - 1)) begin
				proto_errors++;
			end
			wr_cnt++;
			if (wr_cnt == BEATS) begin
				wr_busy = 1'b0;
				wr_bursts++;
			end
		end
		wr_req_ready = !wr_busy && next_ready();
		if (wr_req_valid && wr_req_ready) begin
			if (wr_req_addr[31:14] != '0 || wr_req_addr[4:0] != '0) begin
				proto_errors++;
			end
			wr_busy      = 1'b1;
			wr_base      = int'(wr_req_addr[13:2]);
			wr_cnt       = 0;
			wr_last_addr = wr_req_addr;
		end
	end

endmodule

//--- verif/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

	localparam int SETS  = 32;
	localparam int SET_W = $clog2(SETS);
	localparam int OFF_W = $clog2(cache_geom_pkg::WORDS_PER_LINE) + 2;
	localparam int DEPTH = 4096;
	localparam int LIMIT = 2000;

	logic                     clk;
	logic                     rst;
	logic                     req_valid;
	cache_bus_pkg::cpu_req_t  cpu_req;
	logic                     req_ready;
	logic                     rsp_valid;
	cache_geom_pkg::word_t    rsp_data;
	logic                     rsp_ready;
	logic                     rd_req_valid;
	cache_geom_pkg::word_t    rd_req_addr;
	logic                     rd_req_ready;
	logic                     rd_rsp_valid;
	cache_bus_pkg::mem_beat_t rd_rsp_beat;
	logic                     rd_rsp_ready;
	logic                     wr_req_valid;
	cache_geom_pkg::word_t    wr_req_addr;
	logic                     wr_req_ready;
	logic                     wr_data_valid;
	cache_bus_pkg::mem_beat_t wr_data_beat;
	logic                     wr_data_ready;
	int                       rd_bursts;
	int                       wr_bursts;
	cache_geom_pkg::word_t    wr_last_addr;
	cache_geom_pkg::line_t    wr_last_line;
	int                       proto_errors;

	// expected memory image, updated by every write the test issues
	cache_geom_pkg::word_t exp_mem [DEPTH];
	cache_geom_pkg::word_t got_q [$];
	cache_geom_pkg::word_t exp_q [$];
	cache_geom_pkg::word_t addr_q [$];
	cache_geom_pkg::word_t cmp_got;
	cache_geom_pkg::word_t cmp_exp;
	cache_geom_pkg::word_t cmp_addr;
	logic [31:0]           lcg_state;
	int                    errors;
	int                    tests;
	int                    reads;
	bit                    aborted;

	dcache_top #(.SETS(SETS)) i_dcache_top (
		.clk           (clk),
		.rst           (rst),
		.req_valid     (req_valid),
		.cpu_req       (cpu_req),
		.req_ready     (req_ready),
		.rsp_valid     (rsp_valid),
		.rsp_data      (rsp_data),
		.rsp_ready     (rsp_ready),
		.rd_req_valid  (rd_req_valid),
		.rd_req_addr   (rd_req_addr),
		.rd_req_ready  (rd_req_ready),
		.rd_rsp_valid  (rd_rsp_valid),
		.rd_rsp_beat   (rd_rsp_beat),
		.rd_rsp_ready  (rd_rsp_ready),
		.wr_req_valid  (wr_req_valid),
		.wr_req_addr   (wr_req_addr),
		.wr_req_ready  (wr_req_ready),
		.wr_data_valid (wr_data_valid),
		.wr_data_beat  (wr_data_beat),
		.wr_data_ready (wr_data_ready)
	);

	mem_model i_mem (
		.clk           (clk),
		.rd_req_valid  (rd_req_valid),
		.rd_req_addr   (rd_req_addr),
		.rd_req_ready  (rd_req_ready),
		.rd_rsp_valid  (rd_rsp_valid),
		.rd_rsp_beat   (rd_rsp_beat),
		.rd_rsp_ready  (rd_rsp_ready),
		.wr_req_valid  (wr_req_valid),
		.wr_req_addr   (wr_req_addr),
		.wr_req_ready  (wr_req_ready),
		.wr_data_valid (wr_data_valid),
		.wr_data_beat  (wr_data_beat),
		.wr_data_ready (wr_data_ready),
		.rd_bursts     (rd_bursts),
		.wr_bursts     (wr_bursts),
		.wr_last_addr  (wr_last_addr),
		.wr_last_line  (wr_last_line),
		.proto_errors  (proto_errors)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	function automatic cache_geom_pkg::word_t scramble(input cache_geom_pkg::word_t a);
		return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
	endfunction

	// reference byte merge of a CPU write into the stored word
	function automatic cache_geom_pkg::word_t merge_word(
		input cache_geom_pkg::word_t old,
		input cache_geom_pkg::word_t wdata,
		input cache_geom_pkg::strb_t strb
	);
		cache_geom_pkg::word_t w;
		w = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				w[b*8 +: 8] = wdata[b*8 +: 8];
			end
		end
		return w;
	endfunction

	function automatic cache_geom_pkg::word_t make_addr(input int tag, input int set_idx,
			input int word);
		return cache_geom_pkg::word_t'((tag << (SET_W + OFF_W)) | (set_idx << OFF_W) | (word << 2));
	endfunction

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 8;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic step(inout int cycles, input string what);
		@(negedge clk);
		cycles++;
		if (cycles > LIMIT && !aborted) begin
			$display("timeout: no %s within %0d cycles at %0t", what, LIMIT, $time);
			aborted = 1'b1;
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		if (aborted) begin
			$display("test %-16s aborted", name);
		end else if (errors == err_before) begin
			$display("test %-16s ok", name);
		end else begin
			$display("test %-16s %0d errors", name, errors - err_before);
		end
	endtask

	// one CPU access, lat counts rising edges after the accepting edge
	task automatic access(input logic wr, input cache_geom_pkg::word_t addr,
			input cache_geom_pkg::word_t wdata, input cache_geom_pkg::strb_t strb,
			input bit stall, output int lat);
		int                    cycles;
		int                    idx;
		bit                    done;
		cache_geom_pkg::word_t held;
		cycles = 0;
		lat = 0;
		idx = int'(addr[13:2]);
		while (!req_ready && !aborted) begin
			step(cycles, "req_ready before a request");
		end
		if (aborted) begin
			return;
		end
		req_valid = 1'b1;
		cpu_req = '{wr: wr, addr: addr, wdata: wdata, wstrb: strb};
		@(negedge clk);
		req_valid = 1'b0;
		if (wr) begin
			exp_mem[idx] = merge_word(exp_mem[idx], wdata, strb);
			while (!req_ready && !aborted) begin
				step(lat, "req_ready after a write");
			end
		end else begin
			while (!rsp_valid && !aborted) begin
				step(lat, "rsp_valid for a read");
			end
			held = rsp_data;
			if (!aborted) begin
				got_q.push_back(held);
				exp_q.push_back(exp_mem[idx]);
				addr_q.push_back(addr);
			end
			done = aborted;
			cycles = 0;
			while (!done) begin
				if (rsp_valid !== 1'b1 || rsp_data !== held) begin
					report_mismatch($sformatf("response to %h changed while held", addr));
				end
				if (stall && (lcg_next() % 3 == 0)) begin
					rsp_ready = 1'b0;
				end else begin
					rsp_ready = 1'b1;
					done = 1'b1;
				end
				step(cycles, "response handshake");
				done = done || aborted;
			end
			rsp_ready = 1'b1;
		end
	endtask

	// compares each captured read word with the value expected at issue
	always @(posedge clk) begin
		while (got_q.size() > 0) begin
			cmp_got  = got_q.pop_front();
			cmp_exp  = exp_q.pop_front();
			cmp_addr = addr_q.pop_front();
			reads++;
			if (cmp_got !== cmp_exp) begin
				report_mismatch($sformatf("read %h returned %h, expected %h",
					cmp_addr, cmp_got, cmp_exp));
			end
		end
	end

	task automatic check_reset_state();
		int err0;
		err0 = errors;
		if (req_ready !== 1'b1) begin
			report_mismatch("req_ready is not high after reset");
		end
		if (rsp_valid !== 1'b0 || rd_req_valid !== 1'b0 || wr_req_valid !== 1'b0 ||
				wr_data_valid !== 1'b0 || rd_rsp_ready !== 1'b0) begin
			report_mismatch("a response or memory valid is high after reset");
		end
		end_test("reset_state", err0);
	endtask

	task automatic read_miss_then_hit();
		int                    err0;
		int                    lat;
		int                    bursts;
		cache_geom_pkg::word_t addr;
		err0 = errors;
		addr = make_addr(3, 1, 5);
		bursts = rd_bursts;
		access(1'b0, addr, '0, '0, 1'b0, lat);
		if (!aborted && (lat <= 2 || rd_bursts != bursts + 1)) begin
			report_mismatch($sformatf("read miss took %0d cycles with %0d refills",
				lat, rd_bursts - bursts));
		end
		access(1'b0, addr, '0, '0, 1'b0, lat);
		if (!aborted && (lat != 2 || rd_bursts != bursts + 1)) begin
			report_mismatch($sformatf("read hit took %0d cycles", lat));
		end
		end_test("read_miss_hit", err0);
	endtask

	task automatic strobed_writes();
		int                    err0;
		int                    lat;
		cache_geom_pkg::word_t a_hit;
		cache_geom_pkg::word_t a_miss;
		cache_geom_pkg::word_t a_full;
		err0 = errors;
		a_hit = make_addr(1, 2, 3);
		a_miss = make_addr(2, 3, 6);
		a_full = make_addr(7, 4, 0);
		// bring the first line in, then hit it twice
		access(1'b0, make_addr(1, 2, 0), '0, '0, 1'b0, lat);
		access(1'b1, a_hit, 32'h1122_3344, 4'b0101, 1'b0, lat);
		if (!aborted && lat != 2) begin
			report_mismatch($sformatf("write hit freed req_ready after %0d cycles", lat));
		end
		access(1'b1, a_hit, 32'haabb_ccdd, 4'b1000, 1'b0, lat);
		if (!aborted && lat != 2) begin
			report_mismatch($sformatf("write hit freed req_ready after %0d cycles", lat));
		end
		access(1'b1, a_miss, 32'h0bad_f00d, 4'b0011, 1'b0, lat);
		if (!aborted && lat <= 2) begin
			report_mismatch($sformatf("write miss finished in %0d cycles", lat));
		end
		access(1'b1, a_full, 32'h1234_5678, 4'b1111, 1'b0, lat);
		access(1'b0, a_hit, '0, '0, 1'b0, lat);
		access(1'b0, a_miss, '0, '0, 1'b0, lat);
		access(1'b0, a_miss + 32'd4, '0, '0, 1'b0, lat);
		access(1'b0, a_full, '0, '0, 1'b0, lat);
		end_test("strobed_writes", err0);
	endtask

	task automatic dirty_eviction();
		int                    err0;
		int                    lat;
		int                    bursts;
		int                    perr;
		cache_geom_pkg::word_t victim;
		cache_geom_pkg::line_t exp_line;
		err0 = errors;
		bursts = wr_bursts;
		perr = proto_errors;
		for (int t = 1; t <= 5; t++) begin
			access(1'b1, make_addr(t, 5, t), 32'hc0de_0000 + t, 4'b1111, 1'b0, lat);
		end
		// four fills in way order leave the first tag least recent
		victim = make_addr(1, 5, 0);
		for (int w = 0; w < cache_geom_pkg::WORDS_PER_LINE; w++) begin
			exp_line[w*32 +: 32] = exp_mem[int'(victim[13:2]) + w];
		end
		if (!aborted && wr_bursts != bursts + 1) begin
			report_mismatch($sformatf("%0d write-back bursts seen", wr_bursts - bursts));
		end
		if (!aborted && wr_last_addr !== victim) begin
			report_mismatch($sformatf("write-back to %h, expected %h", wr_last_addr, victim));
		end
		if (!aborted && wr_last_line !== exp_line) begin
			report_mismatch("write-back data differs from the expected line");
		end
		if (!aborted && proto_errors != perr) begin
			report_mismatch("write-back burst has a wrong beat count or last flag");
		end
		access(1'b0, make_addr(1, 5, 1), '0, '0, 1'b0, lat);
		end_test("dirty_eviction", err0);
	endtask

	task automatic plru_order();
		int err0;
		int lat;
		int hit_tags [3];
		err0 = errors;
		for (int t = 1; t <= 4; t++) begin
			access(1'b0, make_addr(t, 9, 0), '0, '0, 1'b0, lat);
		end
		access(1'b0, make_addr(1, 9, 0), '0, '0, 1'b0, lat);
		access(1'b0, make_addr(5, 9, 0), '0, '0, 1'b0, lat);
		// left pair used last, so the older way on the right side went
		hit_tags = '{1, 2, 4};
		for (int i = 0; i < 3; i++) begin
			access(1'b0, make_addr(hit_tags[i], 9, 0), '0, '0, 1'b0, lat);
			if (!aborted && lat != 2) begin
				report_mismatch($sformatf("tag %0d took %0d cycles", hit_tags[i], lat));
			end
		end
		access(1'b0, make_addr(3, 9, 0), '0, '0, 1'b0, lat);
		if (!aborted && lat <= 2) begin
			report_mismatch("evicted tag 3 still hit");
		end
		end_test("plru_order", err0);
	endtask

	task automatic random_backpressure();
		int                    err0;
		int                    perr;
		int                    lat;
		int                    tag;
		int                    set_idx;
		int                    word;
		logic                  wr;
		cache_geom_pkg::word_t wdata;
		cache_geom_pkg::strb_t strb;
		err0 = errors;
		perr = proto_errors;
		for (int n = 0; n < 80 && !aborted; n++) begin
			tag = int'(lcg_next() % 6) + 1;
			set_idx = 12 + int'(lcg_next() % 2);
			word = int'(lcg_next() % 8);
			wr = (lcg_next() % 2) == 1;
			wdata = lcg_next();
			strb = cache_geom_pkg::strb_t'(lcg_next() % 16);
			access(wr, make_addr(tag, set_idx, word), wdata, strb, 1'b1, lat);
		end
		if (!aborted && proto_errors != perr) begin
			report_mismatch("memory bursts broke the beat protocol under stalls");
		end
		end_test("backpressure", err0);
	endtask

	initial begin
		lcg_state = 32'd49;
		errors = 0;
		tests = 0;
		reads = 0;
		aborted = 1'b0;
		rst = 1'b1;
		req_valid = 1'b0;
		cpu_req = '0;
		rsp_ready = 1'b1;
		for (int i = 0; i < DEPTH; i++) begin
			exp_mem[i] = scramble(cache_geom_pkg::word_t'(i) << 2);
		end
		repeat (16) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_reset_state();
		if (!aborted) read_miss_then_hit();
		if (!aborted) strobed_writes();
		if (!aborted) dirty_eviction();
		if (!aborted) plru_order();
		if (!aborted) random_backpressure();
		@(negedge clk);
		$display("tests %0d, reads compared %0d, errors %0d", tests, reads, errors);
		if (aborted || errors != 0) begin
			$display("Regression failed");
		end else begin
			$display("Regression passed");
		end
		$finish;
	end

endmodule
